/* design/decode_pkg.sv */
//##########################################################
// decode stage 1 shared types
// byte window, opcode classes, size codes and the field
// record passed between the classifier and the extractor
//##########################################################

package decode_pkg;

    localparam int BYTE_W       = 8;
    localparam int WINDOW_BYTES = 4;
    localparam int REG_NUM_W    = 3;
    localparam int CLASS_W      = 5;

    typedef logic [BYTE_W-1:0] instr_byte_t;

    // byte 0 is the head of the window
    typedef instr_byte_t [WINDOW_BYTES-1:0] instr_window_t;

    typedef logic [REG_NUM_W-1:0] reg_num_t;
    typedef logic [1:0]           mod_t;
    typedef logic [1:0]           offset_t;

    // two-byte opcode escape
    localparam instr_byte_t OPC_ESCAPE = 8'h0f;

    typedef enum logic [CLASS_W-1:0] {
        CLS_NONE,
        CLS_PREFIX_SEG,
        CLS_PREFIX_OTHER,
        CLS_ALU_RM,
        CLS_ALU_ACC_IMM,
        CLS_ALU_IMM_RM,
        CLS_MOV_RM,
        CLS_MOV_SREG,
        CLS_MOV_IMM_SHORT,
        CLS_PUSH_POP_SHORT,
        CLS_INC_DEC_SHORT,
        CLS_JCC_8,
        CLS_JMP_8,
        CLS_JCC_FULL,
        CLS_MOVX,
        CLS_SHIFT_IMM,
        CLS_SIMPLE
    } op_class_e;

    typedef enum logic [1:0] {
        DISP_NONE = 2'd0,
        DISP_BYTE = 2'd1,
        DISP_FULL = 2'd2
    } disp_len_e;

    typedef enum logic [1:0] {
        IMM_NONE = 2'd0,
        IMM_BYTE = 2'd1,
        IMM_FULL = 2'd2
    } imm_len_e;

    typedef struct packed {
        op_class_e     op_class;
        instr_window_t window;
    } classified_t;

    typedef struct packed {
        logic      is_prefix;
        logic      is_prefix_segment;
        logic      s_present;
        logic      s;
        logic      w_present;
        logic      w;
        logic      greg_present;
        reg_num_t  greg;
        logic      sreg_present;
        reg_num_t  sreg;
        logic      mod_rm_present;
        mod_t      mod;
        reg_num_t  rm;
        disp_len_e disp_len;
        imm_len_e  imm_len;
        offset_t   next_offset;
    } decode_fields_t;

endpackage

/* design/opcode_classify.sv */
//##########################################################
// opcode classifier
// maps the head opcode of the byte window, including the
// 0F two-byte map, onto a small opcode class
//##########################################################

module opcode_classify import decode_pkg::*; (
    input  logic          instr_valid,
    input  instr_window_t instr,
    output logic          cls_valid,
    output classified_t   cls
);

    op_class_e op_class;

    // one-byte opcode map
    function automatic op_class_e classify_primary(instr_byte_t op);
        op_class_e c;
        casez (op)
            // segment overrides ES CS SS DS FS GS
            8'h26, 8'h2e, 8'h36, 8'h3e, 8'h64, 8'h65: begin
                c = CLS_PREFIX_SEG;
            end
            // operand size, address size, lock
            8'h66, 8'h67, 8'hf0: begin
                c = CLS_PREFIX_OTHER;
            end
            // ADD OR ADC SBB AND SUB XOR CMP, low bits 0..3
            8'b00???0??: begin
                c = CLS_ALU_RM;
            end
            // same group, low bits 4 and 5
            8'b00???10?: begin
                c = CLS_ALU_ACC_IMM;
            end
            8'h80, 8'h81, 8'h83: begin
                c = CLS_ALU_IMM_RM;
            end
            8'b100010??: begin
                c = CLS_MOV_RM;
            end
            8'h8c, 8'h8e: begin
                c = CLS_MOV_SREG;
            end
            8'b1011????: begin
                c = CLS_MOV_IMM_SHORT;
            end
            8'b0101????: begin
                c = CLS_PUSH_POP_SHORT;
            end
            8'b0100????: begin
                c = CLS_INC_DEC_SHORT;
            end
            8'b0111????: begin
                c = CLS_JCC_8;
            end
            8'heb: begin
                c = CLS_JMP_8;
            end
            8'hc0, 8'hc1: begin
                c = CLS_SHIFT_IMM;
            end
            // NOP, HLT, CMC, CLC..STD
            8'h90, 8'hf4, 8'hf5, 8'b11111???: begin
                c = (op[2:1] == 2'b11) ? CLS_NONE : CLS_SIMPLE;
            end
            default: begin
                c = CLS_NONE;
            end
        endcase
        return c;
    endfunction

    // second byte after 0F
    function automatic op_class_e classify_escape(instr_byte_t op);
        op_class_e c;
        casez (op)
            8'b1000????: begin
                c = CLS_JCC_FULL;
            end
            // MOVZX B6 B7, MOVSX BE BF
            8'b1011?11?: begin
                c = CLS_MOVX;
            end
            default: begin
                c = CLS_NONE;
            end
        endcase
        return c;
    endfunction

    always_comb begin
        if (instr[0] == OPC_ESCAPE) begin
            op_class = classify_escape(instr[1]);
        end else begin
            op_class = classify_primary(instr[0]);
        end
    end

    assign cls_valid    = instr_valid;
    assign cls.op_class = op_class;
    assign cls.window   = instr;

endmodule

/* design/decode_stage_reg.sv */
//##########################################################
// classifier to extractor pipeline register
// holds the opcode class and byte window for one cycle
//##########################################################

module decode_stage_reg import decode_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        cls_valid,
    input  classified_t cls,
    output logic        held_valid,
    output classified_t held
);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            held_valid <= 1'b0;
        end else begin
            held_valid <= cls_valid;
        end
    end

    // payload loads with the strobe and holds between items
    always_ff @(posedge clk) begin
        if (cls_valid) begin
            held <= cls;
        end
    end

endmodule

/* design/field_extract.sv */
//##########################################################
// field extractor
// applies the per-class field rules to the held window and
// registers the decoded fields
//##########################################################

module field_extract import decode_pkg::*; (
    input  logic           clk,
    input  logic           arst_n,
    input  logic           held_valid,
    input  classified_t    held,
    output logic           decode_valid,
    output decode_fields_t fields
);

    op_class_e      op_class;
    instr_byte_t    b0;
    instr_byte_t    b1;
    instr_byte_t    b2;

    logic           w_at_0_0;
    logic           w_at_0_3;
    logic           w_at_1_0;
    logic           greg_at_0;
    logic           greg_at_1;
    logic           greg_at_2;
    logic           mod_rm_at_1;
    logic           mod_rm_at_2;
    logic           two_byte_opcode;
    decode_fields_t next_fields;

    assign op_class = held.op_class;
    assign b0       = held.window[0];
    assign b1       = held.window[1];
    assign b2       = held.window[2];

    // where each field sits, per class
    assign w_at_0_0 = (op_class == CLS_ALU_RM) || (op_class == CLS_ALU_ACC_IMM)
                   || (op_class == CLS_ALU_IMM_RM) || (op_class == CLS_MOV_RM)
                   || (op_class == CLS_SHIFT_IMM);
    assign w_at_0_3 = (op_class == CLS_MOV_IMM_SHORT);
    assign w_at_1_0 = (op_class == CLS_MOVX);

    assign greg_at_0 = (op_class == CLS_MOV_IMM_SHORT) || (op_class == CLS_PUSH_POP_SHORT)
                    || (op_class == CLS_INC_DEC_SHORT);
    assign greg_at_1 = (op_class == CLS_MOV_RM);
    assign greg_at_2 = (op_class == CLS_MOVX);

    assign mod_rm_at_1 = (op_class == CLS_ALU_RM) || (op_class == CLS_ALU_IMM_RM)
                      || (op_class == CLS_MOV_RM) || (op_class == CLS_MOV_SREG)
                      || (op_class == CLS_SHIFT_IMM);
    assign mod_rm_at_2 = (op_class == CLS_MOVX);

    assign two_byte_opcode = (op_class == CLS_JCC_FULL) || (op_class == CLS_MOVX);

    always_comb begin
        next_fields = '0;

        next_fields.is_prefix_segment = (op_class == CLS_PREFIX_SEG);
        next_fields.is_prefix         = (op_class == CLS_PREFIX_SEG)
                                     || (op_class == CLS_PREFIX_OTHER);

        if (op_class == CLS_ALU_IMM_RM) begin
            next_fields.s_present = 1'b1;
            next_fields.s         = b0[1];
        end

        next_fields.w_present = w_at_0_0 || w_at_0_3 || w_at_1_0;
        next_fields.w         = (w_at_0_0 && b0[0]) || (w_at_0_3 && b0[3])
                             || (w_at_1_0 && b1[0]);

        next_fields.greg_present = greg_at_0 || greg_at_1 || greg_at_2;
        if (greg_at_0) begin
            next_fields.greg = b0[2:0];
        end else if (greg_at_1) begin
            next_fields.greg = b1[5:3];
        end else if (greg_at_2) begin
            next_fields.greg = b2[5:3];
        end

        if (op_class == CLS_MOV_SREG) begin
            next_fields.sreg_present = 1'b1;
            next_fields.sreg         = b1[5:3];
        end

        next_fields.mod_rm_present = mod_rm_at_1 || mod_rm_at_2;
        if (mod_rm_at_1) begin
            next_fields.mod = b1[7:6];
            next_fields.rm  = b1[2:0];
        end else if (mod_rm_at_2) begin
            next_fields.mod = b2[7:6];
            next_fields.rm  = b2[2:0];
        end

        case (op_class)
            CLS_JCC_8, CLS_JMP_8: next_fields.disp_len = DISP_BYTE;
            CLS_JCC_FULL:         next_fields.disp_len = DISP_FULL;
            default:              next_fields.disp_len = DISP_NONE;
        endcase

        case (op_class)
            CLS_ALU_ACC_IMM, CLS_ALU_IMM_RM, CLS_MOV_IMM_SHORT: begin
                next_fields.imm_len = IMM_FULL;
            end
            CLS_SHIFT_IMM: next_fields.imm_len = IMM_BYTE;
            default:       next_fields.imm_len = IMM_NONE;
        endcase

        // opcode bytes plus ModR/M, less one
        next_fields.next_offset = offset_t'(two_byte_opcode)
                                + offset_t'(next_fields.mod_rm_present);
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            decode_valid <= 1'b0;
            fields       <= '0;
        end else begin
            decode_valid <= held_valid;
            // fields hold while no item is in flight
            if (held_valid) begin
                fields <= next_fields;
            end
        end
    end

endmodule

/* design/decode_stage_1.sv */
//##########################################################
// decode stage 1
// classifier, pipeline register and field extractor
//##########################################################

module decode_stage_1 import decode_pkg::*; (
    input  logic           clk,
    input  logic           arst_n,
    input  logic           instr_valid,
    input  instr_window_t  instr,
    output logic           decode_valid,
    output decode_fields_t fields
);

    logic        cls_valid;
    classified_t cls;
    logic        held_valid;
    classified_t held;

    opcode_classify u_classify (
        .instr_valid (instr_valid),
        .instr       (instr),
        .cls_valid   (cls_valid),
        .cls         (cls)
    );

    decode_stage_reg u_stage_reg (
        .clk        (clk),
        .arst_n     (arst_n),
        .cls_valid  (cls_valid),
        .cls        (cls),
        .held_valid (held_valid),
        .held       (held)
    );

    field_extract u_extract (
        .clk          (clk),
        .arst_n       (arst_n),
        .held_valid   (held_valid),
        .held         (held),
        .decode_valid (decode_valid),
        .fields       (fields)
    );

endmodule

/* tb/decode_stage_1_assert.sv */
//##########################################################
// decode stage 1 assertions
// strobe to result timing, reset state, prefix flags
//##########################################################

module decode_stage_1_assert import decode_pkg::*; (
    input logic           clk,
    input logic           arst_n,
    input logic           instr_valid,
    input logic           decode_valid,
    input decode_fields_t fields
);

    timeunit 1ns;
    timeprecision 1ps;

    // result exactly two edges after each strobe, and only then
    strobe_to_result: assert property (@(posedge clk) disable iff (!arst_n)
        decode_valid == $past(instr_valid, 2))
        else $error("decode_valid does not follow the strobe by two cycles");

    no_valid_in_reset: assert property (@(posedge clk)
        !arst_n |-> !decode_valid)
        else $error("decode_valid high during reset");

    segment_is_prefix: assert property (@(posedge clk) disable iff (!arst_n)
        fields.is_prefix_segment |-> fields.is_prefix)
        else $error("segment prefix flag without prefix flag");

endmodule

bind decode_stage_1 decode_stage_1_assert u_assert (
    .clk          (clk),
    .arst_n       (arst_n),
    .instr_valid  (instr_valid),
    .decode_valid (decode_valid),
    .fields       (fields)
);

/* tb/decode_stage_1_tb.sv */
//##########################################################
// decode stage 1 testbench
// table of byte windows and expected fields, driven
// through the DUT with a scoreboard and a cycle limit
//##########################################################

module decode_stage_1_tb import decode_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    typedef struct packed {
        instr_window_t  window;
        decode_fields_t expected;
        logic [3:0]     gap;
    } entry_t;

    logic           clk;
    logic           arst_n;
    logic           instr_valid;
    instr_window_t  instr;
    logic           decode_valid;
    decode_fields_t fields;

    entry_t         table_q[$];
    decode_fields_t exp_q[$];
    int             idx_q[$];

    int             errors;
    int             done_count;
    int             cycles;
    int             timeout_limit = 1000;
    int             cur_idx;
    logic           cur_ok;
    decode_fields_t cur_exp;
    decode_fields_t hold_exp;

    decode_stage_1 u_dut (
        .clk          (clk),
        .arst_n       (arst_n),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .decode_valid (decode_valid),
        .fields       (fields)
    );

    always #50 clk = ~clk;

    function automatic instr_byte_t rnd_byte();
        return instr_byte_t'($urandom);
    endfunction

    function automatic instr_window_t window_of(instr_byte_t b0, instr_byte_t b1,
                                                instr_byte_t b2, instr_byte_t b3);
        instr_window_t w;
        w[0] = b0;
        w[1] = b1;
        w[2] = b2;
        w[3] = b3;
        return w;
    endfunction

    // {present, mod, rm} of a ModR/M byte
    function automatic logic [5:0] modrm_of(instr_byte_t m);
        return {1'b1, m[7:6], m[2:0]};
    endfunction

    // {present, reg} from the reg field of a ModR/M byte
    function automatic logic [3:0] reg_field(instr_byte_t m);
        return {1'b1, m[5:3]};
    endfunction

    // pairs are {present, value}
    // pfx is {is_prefix, is_prefix_segment}
    function automatic decode_fields_t expect_fields(logic [1:0] pfx, logic [1:0] s,
                                                     logic [1:0] w, logic [3:0] greg,
                                                     logic [3:0] sreg, logic [5:0] modrm,
                                                     disp_len_e disp, imm_len_e imm,
                                                     int opcode_bytes);
        decode_fields_t f;
        f = '0;
        {f.is_prefix, f.is_prefix_segment} = pfx;
        {f.s_present, f.s} = s;
        {f.w_present, f.w} = w;
        {f.greg_present, f.greg} = greg;
        {f.sreg_present, f.sreg} = sreg;
        {f.mod_rm_present, f.mod, f.rm} = modrm;
        f.disp_len = disp;
        f.imm_len = imm;
        // opcode bytes plus ModR/M minus one
        f.next_offset = offset_t'(opcode_bytes + int'(modrm[5]) - 1);
        return f;
    endfunction

    task automatic add_entry(instr_window_t w, decode_fields_t e, logic [3:0] gap);
        entry_t t;
        t.window = w;
        t.expected = e;
        t.gap = gap;
        table_q.push_back(t);
    endtask

    task automatic build_table();
        // prefixes
        add_entry(window_of(8'h26, rnd_byte(), rnd_byte(), rnd_byte()),
                  expect_fields(2'b11, 2'b00, 2'b00, 4'h0, 4'h0, 6'h0, DISP_NONE, IMM_NONE, 1), 1);
        add_entry(window_of(8'h65, rnd_byte(), rnd_byte(), rnd_byte()),
                  expect_fields(2'b11, 2'b00, 2'b00, 4'h0, 4'h0, 6'h0, DISP_NONE, IMM_NONE, 1), 0);
        add_entry(window_of(8'h3e, rnd_byte(), rnd_byte(), rnd_byte()),
                  expect_fields(2'b11, 2'b00, 2'b00, 4'h0, 4'h0, 6'h0, DISP_NONE, IMM_NONE, 1), 2);
        add_entry(window_of(8'h66, rnd_byte(), rnd_byte(), rnd_byte()),
                  expect_fields(2'b10, 2'b00, 2'b00, 4'h0, 4'h0, 6'h0, DISP_NONE, IMM_NONE, 1), 1);
        add_entry(window_of(8'hf0, rnd_byte(), rnd_byte(), rnd_byte()),
                  expect_fields(2'b10, 2'b00, 2'b00, 4'h0, 4'h0, 6'h0, DISP_NONE, IMM_NONE, 1), 0);
        add_entry(window_of(8'h67, rnd_byte(), rnd_byte(), rnd_byte()),
                  expect_fields(2'b10, 2'b00, 2'b00, 4'h0, 4'h0, 6'h0, DISP_NONE, IMM_NONE, 1), 1);
        // ALU forms
        add_entry(window_of(8'h01, 8'hd8, rnd_byte(), rnd_byte()),
                  expect_fields(2'b00, 2'b00, 2'b11, 4'h0, 4'h0, modrm_of(8'hd8),
                                DISP_NONE, IMM_NONE, 1), 1);
        add_entry(window_of(8'h32, 8'h45, rnd_byte(), rnd_byte()),
                  expect_fields(2'b00, 2'b00, 2'b10, 4'h0, 4'h0, modrm_of(8'h45),
                                DISP_NONE, IMM_NONE, 1), 0);
        add_entry(window_of(8'h05, rnd_byte(), rnd_byte(), rnd_byte()),
                  expect_fields(2'b00, 2'b00, 2'b11, 4'h0, 4'h0, 6'h0, DISP_NONE, IMM_FULL, 1), 2);
        add_entry(window_of(8'h3c, rnd_byte(), rnd_byte(), rnd_byte()),
                  expect_fields(2'b00, 2'b00, 2'b10, 4'h0, 4'h0, 6'h0, DISP_NONE, IMM_FULL, 1), 1);
        add_entry(window_of(8'h81, 8'hc3, rnd_byte(), rnd_byte()),
                  expect_fields(2'b00, 2'b10, 2'b11, 4'h0, 4'h0, modrm_of(8'hc3),
                                DISP_NONE, IMM_FULL, 1), 1);
        add_entry(window_of(8'h83, 8'h7d, rnd_byte(), rnd_byte()),
                  expect_fields(2'b00, 2'b11, 2'b11, 4'h0, 4'h0, modrm_of(8'h7d),
                                DISP_NONE, IMM_FULL, 1), 0);
        add_entry(window_of(8'h80, 8'h06, rnd_byte(), rnd_byte()),
                  expect_fields(2'b00, 2'b10, 2'b10, 4'h0, 4'h0, modrm_of(8'h06),
                                DISP_NONE, IMM_FULL, 1), 1);
        // MOV and short register forms
        add_entry(window_of(8'h89, 8'hd9, rnd_byte(), rnd_byte()),
                  expect_fields(2'b00, 2'b00, 2'b11, reg_field(8'hd9), 4'h0, modrm_of(8'hd9),
                                DISP_NONE, IMM_NONE, 1), 1);
        add_entry(window_of(8'h8a, 8'h4e, rnd_byte(), rnd_byte()),
                  expect_fields(2'b00, 2'b00, 2'b10, reg_field(8'h4e), 4'h0, modrm_of(8'h4e),
                                DISP_NONE, IMM_NONE, 1), 2);
        add_entry(window_of(8'h8c, 8'hd8, rnd_byte(), rnd_byte()),
                  expect_fields(2'b00, 2'b00, 2'b00, 4'h0, reg_field(8'hd8), modrm_of(8'hd8),
                                DISP_NONE, IMM_NONE, 1), 0);
        add_entry(window_of(8'h8e, 8'h10, rnd_byte(), rnd_byte()),
                  expect_fields(2'b00, 2'b00, 2'b00, 4'h0, reg_field(8'h10), modrm_of(8'h10),
                                DISP_NONE, IMM_NONE, 1), 1);
        add_entry(window_of(8'hb3, rnd_byte(), rnd_byte(), rnd_byte()),
                  expect_fields(2'b00, 2'b00, 2'b10, 4'hb, 4'h0, 6'h0, DISP_NONE, IMM_FULL, 1), 1);
        add_entry(window_of(8'hbe, rnd_byte(), rnd_byte(), rnd_byte()),
                  expect_fields(2'b00, 2'b00, 2'b11, 4'he, 4'h0, 6'h0, DISP_NONE, IMM_FULL, 1), 0);
        add_entry(window_of(8'h55, rnd_byte(), rnd_byte(), rnd_byte()),
                  expect_fields(2'b00, 2'b00, 2'b00, 4'hd, 4'h0, 6'h0, DISP_NONE, IMM_NONE, 1), 1);
        add_entry(window_of(8'h5f, rnd_byte(), rnd_byte(), rnd_byte()),
                  expect_fields(2'b00, 2'b00, 2'b00, 4'hf, 4'h0, 6'h0, DISP_NONE, IMM_NONE, 1), 0);
        add_entry(window_of(8'h41, rnd_byte(), rnd_byte(), rnd_byte()),
                  expect_fields(2'b00, 2'b00, 2'b00, 4'h9, 4'h0, 6'h0, DISP_NONE, IMM_NONE, 1), 2);
        add_entry(window_of(8'h4c, rnd_byte(), rnd_byte(), rnd_byte()),
                  expect_fields(2'b00, 2'b00, 2'b00, 4'hc, 4'h0, 6'h0, DISP_NONE, IMM_NONE, 1), 1);
        // branches
        add_entry(window_of(8'h74, rnd_byte(), rnd_byte(), rnd_byte()),
                  expect_fields(2'b00, 2'b00, 2'b00, 4'h0, 4'h0, 6'h0, DISP_BYTE, IMM_NONE, 1), 0);
        add_entry(window_of(8'h7f, rnd_byte(), rnd_byte(), rnd_byte()),
                  expect_fields(2'b00, 2'b00, 2'b00, 4'h0, 4'h0, 6'h0, DISP_BYTE, IMM_NONE, 1), 1);
        add_entry(window_of(8'heb, rnd_byte(), rnd_byte(), rnd_byte()),
                  expect_fields(2'b00, 2'b00, 2'b00, 4'h0, 4'h0, 6'h0, DISP_BYTE, IMM_NONE, 1), 1);
        add_entry(window_of(8'h0f, 8'h85, rnd_byte(), rnd_byte()),
                  expect_fields(2'b00, 2'b00, 2'b00, 4'h0, 4'h0, 6'h0, DISP_FULL, IMM_NONE, 2), 0);
        add_entry(window_of(8'h0f, 8'h8c, rnd_byte(), rnd_byte()),
                  expect_fields(2'b00, 2'b00, 2'b00, 4'h0, 4'h0, 6'h0, DISP_FULL, IMM_NONE, 2), 2);
        // MOVZX/MOVSX and shift by immediate
        add_entry(window_of(8'h0f, 8'hb6, 8'hc8, rnd_byte()),
                  expect_fields(2'b00, 2'b00, 2'b10, reg_field(8'hc8), 4'h0, modrm_of(8'hc8),
                                DISP_NONE, IMM_NONE, 2), 1);
        add_entry(window_of(8'h0f, 8'hbf, 8'h54, rnd_byte()),
                  expect_fields(2'b00, 2'b00, 2'b11, reg_field(8'h54), 4'h0, modrm_of(8'h54),
                                DISP_NONE, IMM_NONE, 2), 0);
        add_entry(window_of(8'h0f, 8'hbe, 8'h3a, rnd_byte()),
                  expect_fields(2'b00, 2'b00, 2'b10, reg_field(8'h3a), 4'h0, modrm_of(8'h3a),
                                DISP_NONE, IMM_NONE, 2), 1);
        add_entry(window_of(8'hc1, 8'he0, rnd_byte(), rnd_byte()),
                  expect_fields(2'b00, 2'b00, 2'b11, 4'h0, 4'h0, modrm_of(8'he0),
                                DISP_NONE, IMM_BYTE, 1), 1);
        add_entry(window_of(8'hc0, 8'h2b, rnd_byte(), rnd_byte()),
                  expect_fields(2'b00, 2'b00, 2'b10, 4'h0, 4'h0, modrm_of(8'h2b),
                                DISP_NONE, IMM_BYTE, 1), 2);
        // unknown and simple opcodes decode to nothing
        add_entry(window_of(8'hc3, rnd_byte(), rnd_byte(), rnd_byte()), '0, 1);
        add_entry(window_of(8'h0f, 8'h05, rnd_byte(), rnd_byte()), '0, 0);
        add_entry(window_of(8'hff, rnd_byte(), rnd_byte(), rnd_byte()), '0, 1);
        add_entry(window_of(8'h8d, rnd_byte(), rnd_byte(), rnd_byte()), '0, 1);
        add_entry(window_of(8'h90, rnd_byte(), rnd_byte(), rnd_byte()), '0, 0);
        add_entry(window_of(8'hf9, rnd_byte(), rnd_byte(), rnd_byte()), '0, 1);
        // back-to-back burst
        add_entry(window_of(8'h81, 8'hc3, rnd_byte(), rnd_byte()),
                  expect_fields(2'b00, 2'b10, 2'b11, 4'h0, 4'h0, modrm_of(8'hc3),
                                DISP_NONE, IMM_FULL, 1), 0);
        add_entry(window_of(8'h26, rnd_byte(), rnd_byte(), rnd_byte()),
                  expect_fields(2'b11, 2'b00, 2'b00, 4'h0, 4'h0, 6'h0, DISP_NONE, IMM_NONE, 1), 0);
        add_entry(window_of(8'hc3, rnd_byte(), rnd_byte(), rnd_byte()), '0, 0);
        add_entry(window_of(8'h0f, 8'h85, rnd_byte(), rnd_byte()),
                  expect_fields(2'b00, 2'b00, 2'b00, 4'h0, 4'h0, 6'h0, DISP_FULL, IMM_NONE, 2), 0);
        add_entry(window_of(8'hb3, rnd_byte(), rnd_byte(), rnd_byte()),
                  expect_fields(2'b00, 2'b00, 2'b10, 4'hb, 4'h0, 6'h0, DISP_NONE, IMM_FULL, 1), 0);
        add_entry(window_of(8'hc1, 8'he0, rnd_byte(), rnd_byte()),
                  expect_fields(2'b00, 2'b00, 2'b11, 4'h0, 4'h0, modrm_of(8'he0),
                                DISP_NONE, IMM_BYTE, 1), 0);
    endtask

    // scoreboard sampled away from the rising edge
    always @(negedge clk) begin
        if (arst_n && decode_valid) begin
            assert (exp_q.size() != 0) else begin
                $display("decode_valid went high with no item in flight");
                errors++;
            end
            if (exp_q.size() != 0) begin
                cur_exp = exp_q.pop_front();
                cur_idx = idx_q.pop_front();
                cur_ok = 1'b1;
                assert (fields == cur_exp) else begin
                    $display("Error fields expected 0x%h got 0x%h", cur_exp, fields);
                    errors++;
                    cur_ok = 1'b0;
                end
                hold_exp = cur_exp;
                $display("test %0d window 0x%h %s", cur_idx, table_q[cur_idx].window,
                         cur_ok ? "ok" : "mismatch");
                done_count++;
            end
        end else if (arst_n) begin
            // fields keep the last result, all zero before the first one
            assert (fields == hold_exp) else begin
                $display("Error fields expected 0x%h got 0x%h while idle", hold_exp, fields);
                errors++;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= timeout_limit) begin
            $display("timeout, only %0d of %0d results after %0d cycles",
                     done_count, table_q.size(), cycles);
            $display("Some tests failed");
            $finish;
        end
    end

    initial begin
        clk = 1'b0;
        arst_n = 1'b0;
        instr_valid = 1'b0;
        instr = '0;
        errors = 0;
        done_count = 0;
        cycles = 0;
        hold_exp = '0;
        void'($urandom(56));
        build_table();
        timeout_limit = table_q.size() * 4 + 40;

        repeat (5) @(posedge clk);
        #10;
        arst_n = 1'b1;

        foreach (table_q[i]) begin
            @(posedge clk);
            #10;
            instr_valid = 1'b1;
            instr = table_q[i].window;
            exp_q.push_back(table_q[i].expected);
            idx_q.push_back(i);
            // idle cycles carry junk that the payload register must ignore
            repeat (table_q[i].gap) begin
                @(posedge clk);
                #10;
                instr_valid = 1'b0;
                instr = window_of(rnd_byte(), rnd_byte(), rnd_byte(), rnd_byte());
            end
        end
        @(posedge clk);
        #10;
        instr_valid = 1'b0;

        wait (done_count == table_q.size());
        repeat (3) @(posedge clk);

        $display("results %0d of %0d, errors %0d", done_count, table_q.size(), errors);
        if (errors == 0 && done_count == table_q.size()) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

/* decode_stage_1.f */
design/decode_pkg.sv
design/opcode_classify.sv
design/decode_stage_reg.sv
design/field_extract.sv
design/decode_stage_1.sv
tb/decode_stage_1_assert.sv
tb/decode_stage_1_tb.sv

/* Makefile */
# Verilator build and run for the decode stage 1 testbench

TOP = decode_stage_1_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --assert --timing --timescale 1ns/1ps \
		--top-module $(TOP) -Mdir obj_dir -f decode_stage_1.f

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "All tests passed" sim.log

clean:
	rm -rf obj_dir sim.log
